// ==== common/cache_cfg.svh ====
// geometry and test-region macros for the cache test
// CACHE_SETS and CACHE_LINE_BYTES must be powers of two, GEN_IDLE_CYCLES at least 1
`ifndef CACHE_CFG_SVH
`define CACHE_CFG_SVH

// cache geometry, direct mapped
`define CACHE_SETS          8
`define CACHE_LINE_BYTES    64

// derived address split
`define CACHE_OFFSET_BITS   $clog2(`CACHE_LINE_BYTES)
`define CACHE_INDEX_BITS    $clog2(`CACHE_SETS)
`define CACHE_WORD_BITS     $clog2(`CACHE_LINE_BYTES / 8)  // word select within a line

// test region swept by the traffic generator
`define TEST_BASE_ADDR      64'h8000_0000
`define TEST_WORDS          128

// pattern word is {PATTERN_HI, addr[31:0]}
`define PATTERN_HI          32'h0123_4567

`define GEN_IDLE_CYCLES     5  // gap before each request

`endif

// ==== common/cache_pkg.sv ====
// types shared by the cache, the traffic generator and the testbench
// widths follow the macros of cache_cfg.svh
`default_nettype none

`include "cache_cfg.svh"

package cache_pkg;

  localparam int ADDR_BITS = 64;
  localparam int WORD_BITS = 64;
  localparam int LINE_BITS = `CACHE_LINE_BYTES * 8;
  localparam int TAG_BITS  = ADDR_BITS - `CACHE_OFFSET_BITS - `CACHE_INDEX_BITS;

  // op encoding on both request ports
  localparam logic OP_READ  = 1'b0;
  localparam logic OP_WRITE = 1'b1;

  typedef logic [ADDR_BITS-1:0]          addr_t;
  typedef logic [WORD_BITS-1:0]          word_t;
  typedef logic [LINE_BITS-1:0]          line_t;
  typedef logic [TAG_BITS-1:0]           tag_t;
  typedef logic [`CACHE_INDEX_BITS-1:0]  set_idx_t;

  // generator to cache, always a full doubleword
  typedef struct packed {
    logic  op;
    addr_t addr;
    word_t wdata;
  } cache_req_t;

  // cache to memory, one whole line per transaction
  typedef struct packed {
    logic  op;
    addr_t addr;   // line aligned
    line_t wdata;  // victim line on writeback
  } mem_req_t;

  typedef enum logic [2:0] {
    IDLE,
    LOOKUP,
    WRITEBACK,
    REFILL,
    RESPOND
  } ctrl_state_t;

endpackage

`default_nettype wire

// ==== cache/cache_tag_array.sv ====
// tag, valid and dirty per set; lookup result is registered one cycle after i_set
// a fill in the same cycle is forwarded, so the following lookup reports a clean hit
`timescale 1ns/1ps
`default_nettype none

`include "cache_cfg.svh"

module cache_tag_array (
  input  wire logic                 clk,
  input  wire logic                 rst,
  input  wire cache_pkg::set_idx_t  i_set,
  input  wire cache_pkg::tag_t      i_tag,
  input  wire logic                 i_fill,
  input  wire logic                 i_mark_dirty,
  output logic                      o_hit,
  output logic                      o_dirty,
  output cache_pkg::tag_t           o_victim_tag
);

  import cache_pkg::*;

  tag_t                   tag_mem [`CACHE_SETS];
  logic [`CACHE_SETS-1:0] valid_q;
  logic [`CACHE_SETS-1:0] dirty_q;

  always_ff @(posedge clk) begin
    if (rst) begin
      valid_q <= '0;
      dirty_q <= '0;
    end else if (i_fill) begin
      valid_q[i_set] <= 1'b1;
      dirty_q[i_set] <= 1'b0;  // refilled line matches memory
    end else if (i_mark_dirty) begin
      dirty_q[i_set] <= 1'b1;
    end
  end

  always_ff @(posedge clk) begin
    if (i_fill) tag_mem[i_set] <= i_tag;
  end

  // registered lookup
  always_ff @(posedge clk) begin
    if (rst) begin
      o_hit   <= 1'b0;
      o_dirty <= 1'b0;
    end else if (i_fill) begin
      o_hit   <= 1'b1;
      o_dirty <= 1'b0;
    end else begin
      o_hit   <= valid_q[i_set] && (tag_mem[i_set] == i_tag);
      o_dirty <= valid_q[i_set] && dirty_q[i_set];  // victim needs writeback
    end
  end

  always_ff @(posedge clk) begin
    o_victim_tag <= i_fill ? i_tag : tag_mem[i_set];
  end

endmodule

`default_nettype wire

// ==== cache/cache_data_array.sv ====
// one line per set, asynchronous read of the selected word and of the whole line
// a line load takes priority over a word write in the same cycle
`timescale 1ns/1ps
`default_nettype none

`include "cache_cfg.svh"

module cache_data_array (
  input  wire logic                         clk,
  input  wire cache_pkg::set_idx_t          i_set,
  input  wire logic [`CACHE_WORD_BITS-1:0]  i_word_sel,
  input  wire logic                         i_wr_word,
  input  wire cache_pkg::word_t             i_wdata,
  input  wire logic                         i_load_line,
  input  wire cache_pkg::line_t             i_line,
  output cache_pkg::word_t                  o_rdata,
  output cache_pkg::line_t                  o_line
);

  import cache_pkg::*;

  line_t line_mem [`CACHE_SETS];

  always_ff @(posedge clk) begin
    if (i_load_line) begin
      line_mem[i_set] <= i_line;  // refill from memory
    end else if (i_wr_word) begin
      // write hit, merge one doubleword into the line
      line_mem[i_set][i_word_sel*WORD_BITS +: WORD_BITS] <= i_wdata;
    end
  end

  // victim line for writeback
  assign o_line = line_mem[i_set];

  assign o_rdata = o_line[i_word_sel*WORD_BITS +: WORD_BITS];

endmodule

`default_nettype wire

// ==== cache/cache_ctrl.sv ====
// direct-mapped write-back, write-allocate controller, one request at a time
// hit ack two cycles after req_valid; a miss refills and then replays LOOKUP
`timescale 1ns/1ps
`default_nettype none

`include "cache_cfg.svh"

module cache_ctrl (
  input  wire logic                   clk,
  input  wire logic                   rst,
  input  wire cache_pkg::cache_req_t  i_req,
  input  wire logic                   i_req_valid,
  output logic                        o_ack,
  output cache_pkg::word_t            o_rdata,
  output logic                        o_mem_valid,
  output cache_pkg::mem_req_t         o_mem_req,
  input  wire logic                   i_mem_ready,
  input  wire cache_pkg::line_t       i_mem_rdata,
  // tag array
  output cache_pkg::set_idx_t         o_set,
  output cache_pkg::tag_t             o_tag,
  output logic                        o_fill,
  output logic                        o_mark_dirty,
  input  wire logic                   i_hit,
  input  wire logic                   i_dirty,
  input  wire cache_pkg::tag_t        i_victim_tag,
  // data array
  output logic [`CACHE_WORD_BITS-1:0] o_word_sel,
  output logic                        o_wr_word,
  output cache_pkg::word_t            o_wdata,
  output cache_pkg::line_t            o_line,
  input  wire cache_pkg::word_t       i_rdata,
  input  wire cache_pkg::line_t       i_line
);

  import cache_pkg::*;

  ctrl_state_t state;
  cache_req_t  req_q;
  set_idx_t    req_set;
  tag_t        req_tag;
  mem_req_t    refill_req;
  logic        write_hit;

  function automatic addr_t line_addr(tag_t tag, set_idx_t set);
    line_addr = {tag, set, {`CACHE_OFFSET_BITS{1'b0}}};
  endfunction

  assign req_set = req_q.addr[`CACHE_OFFSET_BITS +: `CACHE_INDEX_BITS];
  assign req_tag = req_q.addr[ADDR_BITS-1 -: TAG_BITS];

  // lookup starts from the incoming request while still in IDLE
  assign o_set = (state == IDLE) ? i_req.addr[`CACHE_OFFSET_BITS +: `CACHE_INDEX_BITS] : req_set;
  assign o_tag = (state == IDLE) ? i_req.addr[ADDR_BITS-1 -: TAG_BITS] : req_tag;

  assign refill_req = '{op: OP_READ, addr: line_addr(req_tag, req_set), wdata: '0};

  assign write_hit = (state == LOOKUP) && i_hit && (req_q.op == OP_WRITE);

  always_ff @(posedge clk) begin
    if (rst) begin
      state       <= IDLE;
      o_mem_valid <= 1'b0;
    end else begin
      case (state)
        IDLE: begin
          if (i_req_valid) state <= LOOKUP;
        end
        LOOKUP: begin
          o_mem_valid <= !i_hit;
          if (i_hit) state <= RESPOND;
          else if (i_dirty) state <= WRITEBACK;
          else state <= REFILL;
        end
        WRITEBACK: begin
          if (i_mem_ready) begin
            o_mem_valid <= 1'b0;  // one idle cycle before the refill
            state       <= REFILL;
          end
        end
        REFILL: begin
          if (!o_mem_valid) begin
            o_mem_valid <= 1'b1;
          end else if (i_mem_ready) begin
            o_mem_valid <= 1'b0;
            state       <= LOOKUP;  // replay, completes as a hit
          end
        end
        RESPOND: state <= IDLE;
        default: state <= IDLE;
      endcase
    end
  end

  // request and memory payload
  always_ff @(posedge clk) begin
    if (state == IDLE && i_req_valid) req_q <= i_req;
    if (state == LOOKUP && !i_hit) begin
      if (i_dirty) begin
        o_mem_req <= '{op: OP_WRITE, addr: line_addr(i_victim_tag, req_set), wdata: i_line};
      end else begin
        o_mem_req <= refill_req;
      end
    end
    if (state == WRITEBACK && i_mem_ready) o_mem_req <= refill_req;
  end

  assign o_ack        = (state == RESPOND);
  assign o_rdata      = i_rdata;
  assign o_fill       = (state == REFILL) && o_mem_valid && i_mem_ready;
  assign o_line       = i_mem_rdata;
  assign o_mark_dirty = write_hit;
  assign o_wr_word    = write_hit;
  assign o_wdata      = req_q.wdata;
  assign o_word_sel   = req_q.addr[`CACHE_OFFSET_BITS-1 -: `CACHE_WORD_BITS];

  a_mem_valid_state: assert property (@(posedge clk) disable iff (rst)
    (state == IDLE || state == RESPOND) |-> !o_mem_valid);

  // memory port holds its request until ready
  a_mem_req_stable: assert property (@(posedge clk) disable iff (rst)
    o_mem_valid && !i_mem_ready |=> o_mem_valid && $stable(o_mem_req));

  // requester drops valid in the cycle after the ack pulse
  a_ack_pulse: assert property (@(posedge clk) disable iff (rst)
    o_ack |=> !o_ack && !i_req_valid);

endmodule

`default_nettype wire

// ==== verilog/cache_traffic_gen.sv ====
// two sweeps over the test region: write then readback per word, then reads only
// mismatches are counted on reads; o_done holds once the second sweep ends
`timescale 1ns/1ps
`default_nettype none

`include "cache_cfg.svh"

module cache_traffic_gen (
  input  wire logic               clk,
  input  wire logic               rst,
  output cache_pkg::cache_req_t   o_req,
  output logic                    o_req_valid,
  input  wire logic               i_ack,
  input  wire cache_pkg::word_t   i_rdata,
  output logic                    o_done,
  output logic [15:0]             o_err_count
);

  import cache_pkg::*;

  localparam addr_t BASE_ADDR = `TEST_BASE_ADDR;
  localparam addr_t LAST_ADDR = BASE_ADDR + (`TEST_WORDS - 1) * 8;
  localparam int    GAP_BITS  = $clog2(`GEN_IDLE_CYCLES + 1);

  addr_t               addr_q;
  logic                op_q;
  logic                read_pass_q;  // second sweep
  logic [GAP_BITS-1:0] gap_cnt;
  word_t               expect_word;
  logic                ack_hs;

  assign expect_word = {`PATTERN_HI, addr_q[31:0]};
  assign o_req       = '{op: op_q, addr: addr_q, wdata: expect_word};
  assign ack_hs      = o_req_valid && i_ack;

  always_ff @(posedge clk) begin
    if (rst) begin
      o_req_valid <= 1'b0;
      o_done      <= 1'b0;
      o_err_count <= '0;
      gap_cnt     <= '0;
      addr_q      <= BASE_ADDR;
      op_q        <= OP_WRITE;
      read_pass_q <= 1'b0;
    end else if (ack_hs) begin
      o_req_valid <= 1'b0;
      gap_cnt     <= '0;
      if (op_q == OP_WRITE) begin
        op_q <= OP_READ;  // read back the same word
      end else begin
        if (i_rdata != expect_word) o_err_count <= o_err_count + 16'd1;
        if (addr_q == LAST_ADDR) begin
          addr_q      <= BASE_ADDR;
          read_pass_q <= 1'b1;
          if (read_pass_q) o_done <= 1'b1;
        end else begin
          addr_q <= addr_q + 64'd8;
          op_q   <= read_pass_q ? OP_READ : OP_WRITE;
        end
      end
    end else if (!o_req_valid && !o_done) begin
      // idle gap before the next request
      if (gap_cnt == GAP_BITS'(`GEN_IDLE_CYCLES - 1)) begin
        o_req_valid <= 1'b1;
      end else begin
        gap_cnt <= gap_cnt + 1'b1;
      end
    end
  end

  a_req_stable: assert property (@(posedge clk) disable iff (rst)
    o_req_valid && !i_ack |=> o_req_valid && $stable(o_req));

endmodule

`default_nettype wire

// ==== verilog/cache_test_top.sv ====
// traffic generator in front of the cache, memory side brought out as a line port
// the memory must answer each valid with a one-cycle ready pulse
`timescale 1ns/1ps
`default_nettype none

`include "cache_cfg.svh"

module cache_test_top (
  input  wire logic               clk,
  input  wire logic               rst,
  output logic                    o_mem_valid,
  output cache_pkg::mem_req_t     o_mem_req,
  input  wire logic               i_mem_ready,
  input  wire cache_pkg::line_t   i_mem_rdata,
  output logic                    o_done,
  output logic [15:0]             o_err_count
);

  import cache_pkg::*;

  // generator to cache
  cache_req_t gen_req;
  logic       gen_req_valid;
  logic       cache_ack;
  word_t      cache_rdata;

  // controller to arrays
  set_idx_t                    arr_set;
  tag_t                        arr_tag;
  logic                        fill;
  logic                        mark_dirty;
  logic                        tag_hit;
  logic                        tag_dirty;
  tag_t                        victim_tag;
  logic [`CACHE_WORD_BITS-1:0] word_sel;
  logic                        wr_word;
  word_t                       wr_data;
  word_t                       rd_word;
  line_t                       fill_line;
  line_t                       victim_line;

  cache_traffic_gen u_traffic_gen (
    .clk         (clk),
    .rst         (rst),
    .o_req       (gen_req),
    .o_req_valid (gen_req_valid),
    .i_ack       (cache_ack),
    .i_rdata     (cache_rdata),
    .o_done      (o_done),
    .o_err_count (o_err_count)
  );

  cache_ctrl u_cache_ctrl (
    .clk          (clk),
    .rst          (rst),
    .i_req        (gen_req),
    .i_req_valid  (gen_req_valid),
    .o_ack        (cache_ack),
    .o_rdata      (cache_rdata),
    .o_mem_valid  (o_mem_valid),
    .o_mem_req    (o_mem_req),
    .i_mem_ready  (i_mem_ready),
    .i_mem_rdata  (i_mem_rdata),
    .o_set        (arr_set),
    .o_tag        (arr_tag),
    .o_fill       (fill),
    .o_mark_dirty (mark_dirty),
    .i_hit        (tag_hit),
    .i_dirty      (tag_dirty),
    .i_victim_tag (victim_tag),
    .o_word_sel   (word_sel),
    .o_wr_word    (wr_word),
    .o_wdata      (wr_data),
    .o_line       (fill_line),
    .i_rdata      (rd_word),
    .i_line       (victim_line)
  );

  cache_tag_array u_tag_array (
    .clk          (clk),
    .rst          (rst),
    .i_set        (arr_set),
    .i_tag        (arr_tag),
    .i_fill       (fill),
    .i_mark_dirty (mark_dirty),
    .o_hit        (tag_hit),
    .o_dirty      (tag_dirty),
    .o_victim_tag (victim_tag)
  );

  cache_data_array u_data_array (
    .clk         (clk),
    .i_set       (arr_set),
    .i_word_sel  (word_sel),
    .i_wr_word   (wr_word),
    .i_wdata     (wr_data),
    .i_load_line (fill),
    .i_line      (fill_line),
    .o_rdata     (rd_word),
    .o_line      (victim_line)
  );

endmodule

`default_nettype wire

// ==== verif/tb_mem_model.sv ====
// behavioral line memory for the test region, ready pulse after 0 to 7 extra cycles
// addresses outside the region wrap into it, the testbench flags them separately
`timescale 1ns/1ps
`default_nettype none

`include "cache_cfg.svh"

module tb_mem_model #(
  parameter int SEED = 73
) (
  input  wire logic                 clk,
  input  wire logic                 rst,
  input  wire logic                 i_valid,
  input  wire cache_pkg::mem_req_t  i_req,
  output logic                      o_ready,
  output cache_pkg::line_t          o_rdata
);

  import cache_pkg::*;

  localparam int LINE_WORDS = `CACHE_LINE_BYTES / 8;

  word_t mem_words [`TEST_WORDS];

  function automatic int word_index(addr_t addr);
    addr_t offs;
    offs = addr - `TEST_BASE_ADDR;
    word_index = int'((offs >> 3) % `TEST_WORDS);
  endfunction

  initial begin : serve
    int unsigned delay;
    int          base;
    addr_t       word_addr;
    delay   = $urandom(SEED);  // seeds this process once
    o_ready = 1'b0;
    o_rdata = '0;
    // start from the inverse of the pattern so stale data shows up
    for (int i = 0; i < `TEST_WORDS; i++) begin
      word_addr    = `TEST_BASE_ADDR + 8 * i;
      mem_words[i] = ~{`PATTERN_HI, word_addr[31:0]};
    end
    forever begin
      @(posedge clk);
      #1;
      if (!rst && i_valid) begin
        delay = $urandom % 8;
        if (delay > 0) begin
          repeat (delay) @(posedge clk);
          #1;
        end
        base = word_index(i_req.addr);
        for (int k = 0; k < LINE_WORDS; k++) begin
          if (i_req.op == OP_WRITE) begin
            mem_words[(base + k) % `TEST_WORDS] = i_req.wdata[k*64 +: 64];
          end else begin
            o_rdata[k*64 +: 64] = mem_words[(base + k) % `TEST_WORDS];
          end
        end
        o_ready = 1'b1;
        @(posedge clk);  // handshake taken here
        #1;
        o_ready = 1'b0;
      end
    end
  end

endmodule

`default_nettype wire

// ==== verif/tb_cache_test_top.sv ====
// self-checking testbench for the cache test top with a random-latency line memory
// expects the fixed two-sweep traffic of the generator over the 1 KiB region
`timescale 1ns/1ps
`default_nettype none

`include "cache_cfg.svh"

module tb_cache_test_top;

  import cache_pkg::*;

  localparam int    CLK_PERIOD = 100;
  localparam int    MAX_CYCLES = 20000;  // 384 accesses x ~40 cycles worst miss, plus margin
  localparam int    NUM_LINES  = `TEST_WORDS * 8 / `CACHE_LINE_BYTES;
  localparam int    LINE_WORDS = `CACHE_LINE_BYTES / 8;
  localparam addr_t BASE_ADDR  = `TEST_BASE_ADDR;
  localparam addr_t END_ADDR   = BASE_ADDR + `TEST_WORDS * 8;
  localparam addr_t LAST_LINE  = BASE_ADDR + (NUM_LINES - 1) * `CACHE_LINE_BYTES;
  // one refill per line and sweep; lines past the set count evict a dirty victim
  localparam logic [15:0] SWEEP_READS  = NUM_LINES;
  localparam logic [15:0] SWEEP_WRITES = NUM_LINES - `CACHE_SETS;

  logic        clk;
  logic        rst;
  logic        mem_valid;
  mem_req_t    mem_req;
  logic        mem_ready;
  line_t       mem_rdata;
  logic        done;
  logic [15:0] err_count;

  int          error_count;
  int          cycle_count;
  int          sweep;        // 0 until the last line was refilled once
  logic [15:0] read_cnt [2];
  logic [15:0] write_cnt [2];

  cache_test_top u_cache_test_top (
    .clk         (clk),
    .rst         (rst),
    .o_mem_valid (mem_valid),
    .o_mem_req   (mem_req),
    .i_mem_ready (mem_ready),
    .i_mem_rdata (mem_rdata),
    .o_done      (done),
    .o_err_count (err_count)
  );

  tb_mem_model #(.SEED(73)) u_mem_model (
    .clk     (clk),
    .rst     (rst),
    .i_valid (mem_valid),
    .i_req   (mem_req),
    .o_ready (mem_ready),
    .o_rdata (mem_rdata)
  );

  function automatic word_t pattern_word(addr_t addr);
    pattern_word = {`PATTERN_HI, addr[31:0]};
  endfunction

  task automatic check_word(word_t actual, word_t expected, string what);
    if (actual !== expected) begin
      error_count++;
      $display("Error at %0t: %s is %h, expected %h", $time, what, actual, expected);
    end
  endtask

  task automatic check_count(logic [15:0] actual, logic [15:0] expected, string what);
    if (actual !== expected) begin
      error_count++;
      $display("Error at %0t: %s is %0d, expected %0d", $time, what, actual, expected);
    end
  endtask

  task automatic check_flag(logic actual, logic expected, string what);
    if (actual !== expected) begin
      error_count++;
      $display("Error at %0t: %s is %b, expected %b", $time, what, actual, expected);
    end
  endtask

  task automatic check_addr(addr_t addr, string what);
    logic ok;
    ok = ((addr % `CACHE_LINE_BYTES) == 0) && (addr >= BASE_ADDR) && (addr < END_ADDR);
    if (ok !== 1'b1) begin
      error_count++;
      $display("Error at %0t: %s %h is not an aligned line in the region", $time, what, addr);
    end
  endtask

  initial begin
    clk = 1'b0;
    forever #(CLK_PERIOD / 2) clk = ~clk;
  end

  // memory handshakes, sampled mid-cycle before the edge that takes them
  always @(negedge clk) begin : monitor
    addr_t word_addr;
    if (!rst && mem_valid && mem_ready) begin
      check_addr(mem_req.addr, "memory request address");
      if (mem_req.op == OP_WRITE) begin
        write_cnt[sweep] = write_cnt[sweep] + 16'd1;
        for (int k = 0; k < LINE_WORDS; k++) begin
          word_addr = mem_req.addr + 8 * k;
          check_word(mem_req.wdata[k*64 +: 64], pattern_word(word_addr),
                     $sformatf("writeback word at %h", word_addr));
        end
      end else begin
        read_cnt[sweep] = read_cnt[sweep] + 16'd1;
        if (mem_req.addr == LAST_LINE) sweep = 1;  // first sweep has no more misses
      end
    end
  end

  initial begin : watchdog
    cycle_count = 0;
    while (cycle_count < MAX_CYCLES) begin
      @(posedge clk);
      cycle_count++;
    end
    $display("run did not finish: o_done not seen within %0d cycles, %0d errors so far",
             MAX_CYCLES, error_count);
    $display("TEST RESULT: FAIL");
    $finish;
  end

  initial begin : main
    addr_t word_addr;
    rst          = 1'b1;
    error_count  = 0;
    sweep        = 0;
    read_cnt[0]  = '0;
    read_cnt[1]  = '0;
    write_cnt[0] = '0;
    write_cnt[1] = '0;
    repeat (2) @(posedge clk);
    #1;
    rst = 1'b0;
    check_flag(mem_valid, 1'b0, "o_mem_valid after reset");
    check_flag(done, 1'b0, "o_done after reset");
    check_count(err_count, 16'd0, "o_err_count after reset");

    while (done !== 1'b1) @(negedge clk);
    check_count(err_count, 16'd0, "o_err_count at done");
    check_count(read_cnt[0], SWEEP_READS, "refills in first sweep");
    check_count(write_cnt[0], SWEEP_WRITES, "writebacks in first sweep");
    check_count(read_cnt[1], SWEEP_READS, "refills in second sweep");
    check_count(write_cnt[1], SWEEP_WRITES, "writebacks in second sweep");
    check_count(read_cnt[0] + read_cnt[1], 2 * SWEEP_READS, "total memory reads");
    check_count(write_cnt[0] + write_cnt[1], 2 * SWEEP_WRITES, "total memory writes");

    // every line has been written back by now
    for (int i = 0; i < `TEST_WORDS; i++) begin
      word_addr = BASE_ADDR + 8 * i;
      check_word(u_mem_model.mem_words[i], pattern_word(word_addr),
                 $sformatf("memory word at %h", word_addr));
    end

    $display("errors: %0d", error_count);
    if (error_count == 0) begin
      $display("TEST RESULT: PASS");
    end else begin
      $display("TEST RESULT: FAIL");
    end
    $finish;
  end

endmodule

`default_nettype wire

// ==== cache_test_top.f ====
+incdir+common
common/cache_pkg.sv
cache/cache_tag_array.sv
cache/cache_data_array.sv
cache/cache_ctrl.sv
verilog/cache_traffic_gen.sv
verilog/cache_test_top.sv
verif/tb_mem_model.sv
verif/tb_cache_test_top.sv
